// File: Makefile
# Verilator build and run of the SoC testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_soc with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_soc
	./obj_dir/Vtb_soc > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "Result: failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "Result: run incomplete"; exit 1; fi
	@echo "Result: passed"

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
+incdir+verilog
+incdir+dv
verilog/soc_pkg.sv
verilog/mem_bus_if.sv
verilog/rv_regfile.sv
verilog/rv_core.sv
verilog/soc_ram.sv
verilog/soc_sysctl.sv
verilog/soc_top.sv
dv/tb_soc.sv

// File: dv/tb_rv_asm.svh
// RV32I encoders for the supported subset, included inside the testbench module
// Offsets are byte offsets and are not range checked
`ifndef TB_RV_ASM_SVH
`define TB_RV_ASM_SVH

// =========================================================================
// Instruction formats
// =========================================================================
function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
        input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type_word(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

// Bit 0 of the branch offset is dropped
function automatic logic [31:0] b_type_word(input logic [12:0] off, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

// =========================================================================
// Instructions
// =========================================================================
function automatic logic [31:0] add_op(input logic [4:0] rd, rs1, rs2);
    return r_type_word(7'd0, rs2, rs1, 3'b000, rd, OPC_OP);
endfunction

function automatic logic [31:0] sub_op(input logic [4:0] rd, rs1, rs2);
    return r_type_word(7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP);
endfunction

function automatic logic [31:0] sll_op(input logic [4:0] rd, rs1, rs2);
    return r_type_word(7'd0, rs2, rs1, 3'b001, rd, OPC_OP);
endfunction

function automatic logic [31:0] xor_op(input logic [4:0] rd, rs1, rs2);
    return r_type_word(7'd0, rs2, rs1, 3'b100, rd, OPC_OP);
endfunction

function automatic logic [31:0] or_op(input logic [4:0] rd, rs1, rs2);
    return r_type_word(7'd0, rs2, rs1, 3'b110, rd, OPC_OP);
endfunction

function automatic logic [31:0] and_op(input logic [4:0] rd, rs1, rs2);
    return r_type_word(7'd0, rs2, rs1, 3'b111, rd, OPC_OP);
endfunction

function automatic logic [31:0] addi_op(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return i_type_word(imm, rs1, 3'b000, rd, OPC_OP_IMM);
endfunction

function automatic logic [31:0] slli_op(input logic [4:0] rd, rs1, input logic [4:0] sh);
    return i_type_word({7'd0, sh}, rs1, 3'b001, rd, OPC_OP_IMM);
endfunction

function automatic logic [31:0] lw_op(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return i_type_word(imm, rs1, 3'b010, rd, OPC_LOAD);
endfunction

function automatic logic [31:0] sw_op(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    return s_type_word(imm, rs2, rs1, 3'b010);
endfunction

function automatic logic [31:0] beq_op(input logic [4:0] rs1, rs2, input logic [12:0] off);
    return b_type_word(off, rs2, rs1, 3'b000);
endfunction

function automatic logic [31:0] bne_op(input logic [4:0] rs1, rs2, input logic [12:0] off);
    return b_type_word(off, rs2, rs1, 3'b001);
endfunction

function automatic logic [31:0] blt_op(input logic [4:0] rs1, rs2, input logic [12:0] off);
    return b_type_word(off, rs2, rs1, 3'b100);
endfunction

function automatic logic [31:0] jal_op(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

function automatic logic [31:0] lui_op(input logic [4:0] rd, input logic [19:0] upper);
    return {upper, rd, OPC_LUI};
endfunction

`endif

// File: dv/tb_soc.sv
// Directed tests of soc_top with programs loaded through the host port during rst
// Words 0xE0 to 0xFF hold data and get an address pattern before every test
`include "soc_consts.svh"

module tb_soc;
    import soc_pkg::*;

    `include "tb_rv_asm.svh"

    localparam int         NUM_TESTS       = 5;
    localparam int         RUN_CYCLES      = 3000;
    localparam int         WATCHDOG_CYCLES = NUM_TESTS * 4000;
    localparam logic [7:0] DATA_WORD       = 8'hE0;

    logic        clk = 1'b0;
    logic        rst;
    logic        host_we;
    logic [7:0]  host_addr;
    logic [31:0] host_wdata;
    logic [31:0] host_rdata;
    logic        led;
    logic        done;
    logic        trap;

    logic [31:0] prog [$];
    logic        led_log [$];
    logic        led_seen = 1'b0;
    logic [31:0] lfsr = 32'h0f3b_cf13;
    int          errors = 0;
    int          failed = 0;

    soc_top i_soc_top (
        .clk        (clk),
        .rst        (rst),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .led        (led),
        .done       (done),
        .trap       (trap)
    );

    always #5 clk = ~clk;

    // Record every LED change seen at a clock edge
    always @(posedge clk) begin
        if (led != led_seen) begin
            led_log.push_back(led);
            led_seen = led;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a test is stuck", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    // =========================================================================
    // Helpers
    // =========================================================================
    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < width; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        host_we    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        @(posedge clk);
        #1;
        host_we = 1'b0;
    endtask

    // host_rdata is registered and trails host_addr by one cycle
    task automatic host_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        host_addr = addr;
        @(posedge clk);
        #1;
        data = host_rdata;
    endtask

    // Sets done and then spins on a self-jump
    task automatic push_finish();
        prog.push_back(addi_op(5'd31, 5'd0, 12'd1));
        prog.push_back(sw_op(5'd31, 5'd0, 12'(`ADDR_DONE)));
        prog.push_back(jal_op(5'd0, 21'd0));
    endtask

    task automatic load_program();
        @(posedge clk);
        #1;
        rst = 1'b1;
        // Each data word gets a value unique to its address
        for (int w = DATA_WORD; w < `RAM_WORDS; w++) begin
            host_write(8'(w), 32'hDEAD_0000 | 32'(w));
        end
        foreach (prog[i]) begin
            host_write(8'(i), prog[i]);
        end
    endtask

    task automatic run_program(input bit expect_trap);
        int cycles;
        cycles = 0;
        led_log.delete();
        @(posedge clk);
        #1;
        rst = 1'b0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!done && !trap && cycles < RUN_CYCLES);
        assert (done || trap) else begin
            $display("ERROR at %0t: program raised neither done nor trap in %0d cycles",
                     $time, RUN_CYCLES);
            errors++;
        end
        check_value("trap", 32'(trap), 32'(expect_trap));
        check_value("done", 32'(done), 32'(!expect_trap));
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
            failed++;
        end
    endtask

    // =========================================================================
    // Tests
    // =========================================================================
    task automatic test_doubler();
        logic [31:0] got;
        int          n;
        int          e0;
        e0 = errors;
        n  = int'(random_bits(5)) % 31 + 1;
        prog.delete();
        prog.push_back(addi_op(5'd1, 5'd0, 12'h3F0));
        prog.push_back(lw_op(5'd2, 5'd1, 12'd0));
        prog.push_back(addi_op(5'd3, 5'd0, 12'd1));
        prog.push_back(add_op(5'd3, 5'd3, 5'd3));
        prog.push_back(addi_op(5'd2, 5'd2, 12'hFFF));
        // Back to the add while the count is nonzero
        prog.push_back(bne_op(5'd2, 5'd0, 13'h1FF8));
        prog.push_back(sw_op(5'd3, 5'd1, 12'd4));
        push_finish();
        load_program();
        host_write(8'hFC, 32'(n));
        run_program(1'b0);
        host_read(8'hFD, got);
        check_value($sformatf("doubler result for n=%0d", n), got, 32'd1 << n);
        report_test("doubler", e0);
    endtask

    task automatic test_alu();
        string       names [9];
        logic [31:0] ops [9];
        logic [31:0] exp [9];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] got;
        logic [11:0] imm;
        logic [4:0]  sh;
        logic [19:0] up;
        int          e0;
        e0    = errors;
        a     = random_bits(32);
        b     = random_bits(32);
        imm   = 12'(random_bits(12));
        sh    = 5'(random_bits(5));
        up    = 20'(random_bits(20));
        names = '{"add", "sub", "and", "or", "xor", "sll", "slli", "addi", "lui"};
        ops   = '{add_op(5'd4, 5'd2, 5'd3), sub_op(5'd4, 5'd2, 5'd3),
                  and_op(5'd4, 5'd2, 5'd3), or_op(5'd4, 5'd2, 5'd3),
                  xor_op(5'd4, 5'd2, 5'd3), sll_op(5'd4, 5'd2, 5'd3),
                  slli_op(5'd4, 5'd2, sh), addi_op(5'd4, 5'd2, imm), lui_op(5'd4, up)};
        exp   = '{a + b, a - b, a & b, a | b, a ^ b, a << b[4:0], a << sh,
                  a + {{20{imm[11]}}, imm}, {up, 12'd0}};
        prog.delete();
        prog.push_back(addi_op(5'd1, 5'd0, 12'h380));
        prog.push_back(lw_op(5'd2, 5'd1, 12'h060));
        prog.push_back(lw_op(5'd3, 5'd1, 12'h064));
        for (int k = 0; k < 9; k++) begin
            prog.push_back(ops[k]);
            prog.push_back(sw_op(5'd4, 5'd1, 12'(4 * k)));
        end
        push_finish();
        load_program();
        host_write(8'hF8, a);
        host_write(8'hF9, b);
        run_program(1'b0);
        for (int k = 0; k < 9; k++) begin
            host_read(DATA_WORD + 8'(k), got);
            check_value(names[k], got, exp[k]);
        end
        report_test("alu", e0);
    endtask

    task automatic test_branches();
        logic [31:0] br [6];
        bit          taken [6];
        logic [31:0] got;
        int          v2;
        int          v3;
        int          v4;
        int          link_pc;
        int          e0;
        e0    = errors;
        v2    = 5;
        v3    = 5;
        v4    = -3;
        br    = '{beq_op(5'd2, 5'd3, 13'd12), beq_op(5'd2, 5'd4, 13'd12),
                  bne_op(5'd2, 5'd4, 13'd12), bne_op(5'd2, 5'd3, 13'd12),
                  blt_op(5'd4, 5'd2, 13'd12), blt_op(5'd2, 5'd4, 13'd12)};
        taken = '{v2 == v3, v2 == v4, v2 != v4, v2 != v3, v4 < v2, v2 < v4};
        prog.delete();
        prog.push_back(addi_op(5'd1, 5'd0, 12'h380));
        prog.push_back(addi_op(5'd2, 5'd0, 12'(v2)));
        prog.push_back(addi_op(5'd3, 5'd0, 12'(v3)));
        prog.push_back(addi_op(5'd4, 5'd0, 12'(v4)));
        for (int k = 0; k < 6; k++) begin
            // Fall-through marks 0x100+k and the taken target 0x200+k
            prog.push_back(br[k]);
            prog.push_back(addi_op(5'd6, 5'd0, 12'(12'h100 + k)));
            prog.push_back(jal_op(5'd0, 21'd8));
            prog.push_back(addi_op(5'd6, 5'd0, 12'(12'h200 + k)));
            prog.push_back(sw_op(5'd6, 5'd1, 12'(4 * k)));
        end
        // JAL skips a write that would clear the link
        link_pc = prog.size() * 4;
        prog.push_back(jal_op(5'd5, 21'd8));
        prog.push_back(addi_op(5'd5, 5'd0, 12'd0));
        prog.push_back(sw_op(5'd5, 5'd1, 12'd24));
        push_finish();
        load_program();
        run_program(1'b0);
        for (int k = 0; k < 6; k++) begin
            host_read(DATA_WORD + 8'(k), got);
            check_value($sformatf("branch %0d marker", k), got,
                        32'(taken[k] ? 32'h200 + k : 32'h100 + k));
        end
        host_read(DATA_WORD + 8'd6, got);
        check_value("jal link", got, 32'(link_pc + 4));
        report_test("branches", e0);
    endtask

    task automatic test_blinky();
        int e0;
        e0 = errors;
        prog.delete();
        prog.push_back(addi_op(5'd1, 5'd0, 12'd1));
        for (int k = 0; k < 3; k++) begin
            prog.push_back(sw_op((k == 1) ? 5'd0 : 5'd1, 5'd0, 12'(`ADDR_LED)));
            prog.push_back(addi_op(5'd2, 5'd0, 12'd20));
            prog.push_back(addi_op(5'd2, 5'd2, 12'hFFF));
            prog.push_back(bne_op(5'd2, 5'd0, 13'h1FFC));
        end
        push_finish();
        load_program();
        run_program(1'b0);
        check_value("led at done", 32'(led), 32'd1);
        check_value("led change count", 32'(led_log.size()), 32'd3);
        for (int k = 0; k < 3 && k < led_log.size(); k++) begin
            check_value($sformatf("led change %0d", k), 32'(led_log[k]), 32'(k != 1));
        end
        report_test("blinky", e0);
    endtask

    task automatic test_trap_reset();
        int e0;
        e0 = errors;
        // Light the LED and set done so the next rst has both to clear
        prog.delete();
        prog.push_back(addi_op(5'd1, 5'd0, 12'd1));
        prog.push_back(sw_op(5'd1, 5'd0, 12'(`ADDR_LED)));
        push_finish();
        load_program();
        run_program(1'b0);
        check_value("led before rst", 32'(led), 32'd1);
        prog.delete();
        // Major opcode 7'h7F is not in the subset
        prog.push_back(32'h0000_007F);
        push_finish();
        load_program();
        check_value("done after rst", 32'(done), 32'd0);
        check_value("led after rst", 32'(led), 32'd0);
        run_program(1'b1);
        repeat (20) @(posedge clk);
        #1;
        check_value("done while trapped", 32'(done), 32'd0);
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        check_value("trap after rst", 32'(trap), 32'd0);
        report_test("trap_reset", e0);
    endtask

    initial begin
        rst        = 1'b1;
        host_we    = 1'b0;
        host_addr  = 8'd0;
        host_wdata = 32'd0;
        repeat (10) @(posedge clk);
        test_doubler();
        test_alu();
        test_branches();
        test_blinky();
        test_trap_reset();
        $display("tests: %0d run, %0d failed, %0d errors", NUM_TESTS, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verilog/mem_bus_if.sv
// Word bus with req/gnt handshake, read data one cycle after gnt
// Requester holds req, addr, we and wdata until gnt
interface mem_bus_if;

    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        gnt;
    logic [31:0] rdata;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport responder (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

// File: verilog/rv_core.sv
// Multi-cycle RV32I subset core, word loads and stores only
// Unsupported encodings park the core in TRAP until rst
`include "soc_consts.svh"

module rv_core (
    input  logic         clk,
    input  logic         rst,
    mem_bus_if.requester bus,
    output logic         trap
);
    import soc_pkg::*;

    core_state_e state_q;
    core_state_e state_d;
    logic        started_q;
    logic [31:0] pc_q;
    logic [31:0] next_pc_q;
    logic [31:0] instr_q;
    logic [31:0] result_q;
    logic [31:0] pc_plus4;
    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        branch_taken;
    logic [2:0]  f3;
    logic [6:0]  f7;
    opcode_e     opcode;
    decoded_t    dec;

    rv_regfile i_regfile (
        .clk      (clk),
        .rs1_addr (dec.rs1),
        .rs2_addr (dec.rs2),
        .rd_addr  (dec.rd),
        .rd_we    (state_q == ST_WRITEBACK && dec.reg_write),
        .rd_data  (result_q),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // ========================================================================
    // Decode, valid from EXECUTE to WRITEBACK while instr_q is stable
    // ========================================================================
    assign opcode = opcode_e'(instr_q[6:0]);
    assign f3     = instr_q[14:12];
    assign f7     = instr_q[31:25];

    always_comb begin
        dec           = '0;
        dec.rs1       = instr_q[19:15];
        dec.rs2       = instr_q[24:20];
        dec.rd        = instr_q[11:7];
        dec.funct3    = f3;
        dec.alu_op    = ALU_ADD;
        dec.use_imm   = 1'b1;
        // I-type immediate unless overridden
        dec.imm       = {{20{instr_q[31]}}, instr_q[31:20]};
        case (opcode)
            OPC_LUI: begin
                dec.imm       = {instr_q[31:12], 12'd0};
                dec.alu_op    = ALU_PASS_B;
                dec.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                dec.reg_write = 1'b1;
                if (f3 == 3'b001 && f7 == 7'd0) begin
                    dec.alu_op = ALU_SLL;
                end else if (f3 != 3'b000) begin
                    dec.illegal = 1'b1;
                end
            end
            OPC_OP: begin
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b0;
                if (f7 == 7'b0100000 && f3 == 3'b000) begin
                    dec.alu_op = ALU_SUB;
                end else if (f7 != 7'd0) begin
                    dec.illegal = 1'b1;
                end else begin
                    case (f3)
                        3'b000:  dec.alu_op  = ALU_ADD;
                        3'b001:  dec.alu_op  = ALU_SLL;
                        3'b100:  dec.alu_op  = ALU_XOR;
                        3'b110:  dec.alu_op  = ALU_OR;
                        3'b111:  dec.alu_op  = ALU_AND;
                        default: dec.illegal = 1'b1;
                    endcase
                end
            end
            OPC_LOAD: begin
                dec.is_load   = 1'b1;
                dec.reg_write = 1'b1;
                dec.illegal   = (f3 != 3'b010);
            end
            OPC_STORE: begin
                dec.imm      = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
                dec.is_store = 1'b1;
                dec.illegal  = (f3 != 3'b010);
            end
            OPC_BRANCH: begin
                dec.imm       = {{19{instr_q[31]}}, instr_q[31], instr_q[7],
                                 instr_q[30:25], instr_q[11:8], 1'b0};
                dec.is_branch = 1'b1;
                dec.illegal   = !(f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b100);
            end
            OPC_JAL: begin
                dec.imm       = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12],
                                 instr_q[20], instr_q[30:21], 1'b0};
                dec.is_jump   = 1'b1;
                dec.reg_write = 1'b1;
            end
            default: dec.illegal = 1'b1;
        endcase
    end

    // ALU and branch compare
    assign op_b     = dec.use_imm ? dec.imm : rs2_data;
    assign pc_plus4 = pc_q + 32'd4;

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:    alu_out = rs1_data - op_b;
            ALU_AND:    alu_out = rs1_data & op_b;
            ALU_OR:     alu_out = rs1_data | op_b;
            ALU_XOR:    alu_out = rs1_data ^ op_b;
            ALU_SLL:    alu_out = rs1_data << op_b[4:0];
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = rs1_data + op_b;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  branch_taken = (rs1_data == rs2_data);
            3'b001:  branch_taken = (rs1_data != rs2_data);
            3'b100:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            default: branch_taken = 1'b0;
        endcase
    end

    // ========================================================================
    // Control FSM
    // ========================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_FETCH:      if (bus.gnt) state_d = ST_WAIT_INSTR;
            ST_WAIT_INSTR: state_d = ST_EXECUTE;
            ST_EXECUTE: begin
                if (dec.illegal) begin
                    state_d = ST_TRAP;
                end else if (dec.is_load || dec.is_store) begin
                    state_d = ST_MEM;
                end else begin
                    state_d = ST_WRITEBACK;
                end
            end
            ST_MEM:        if (bus.gnt) state_d = ST_WAIT_DATA;
            ST_WAIT_DATA:  state_d = ST_WRITEBACK;
            ST_WRITEBACK:  state_d = ST_FETCH;
            default:       state_d = ST_TRAP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_FETCH;
            pc_q      <= `RESET_PC;
            started_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            started_q <= 1'b1;
            if (state_q == ST_WRITEBACK) begin
                pc_q <= next_pc_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_WAIT_INSTR) begin
            instr_q <= bus.rdata;
        end
        if (state_q == ST_EXECUTE) begin
            // JAL links pc+4, loads and stores keep their address here
            result_q  <= dec.is_jump ? pc_plus4 : alu_out;
            next_pc_q <= (dec.is_jump || (dec.is_branch && branch_taken)) ?
                         pc_q + dec.imm : pc_plus4;
        end
        if (state_q == ST_WAIT_DATA && dec.is_load) begin
            result_q <= bus.rdata;
        end
    end

    // Bus requests; first fetch waits one cycle after rst drops
    assign bus.req   = started_q && (state_q == ST_FETCH || state_q == ST_MEM);
    assign bus.addr  = (state_q == ST_MEM) ? result_q : pc_q;
    assign bus.we    = (state_q == ST_MEM) && dec.is_store;
    assign bus.wdata = rs2_data;

    assign trap = (state_q == ST_TRAP);

    // Branch and jump targets must keep fetches word aligned
    a_addr_aligned: assert property (@(posedge clk) disable iff (rst)
        bus.req |-> bus.addr[1:0] == 2'b00);

    a_req_held: assert property (@(posedge clk) disable iff (rst)
        bus.req && !bus.gnt |=> bus.req && $stable(bus.addr));

endmodule

// File: verilog/rv_regfile.sv
// 31 writable registers, x0 reads as zero
module rv_regfile (
    input  logic        clk,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic [4:0]  rd_addr,
    input  logic        rd_we,
    input  logic [31:0] rd_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    // No storage behind x0
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Asynchronous read ports
    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

// File: verilog/soc_consts.svh
// SoC sizing and memory map. The RAM must stay below ADDR_DONE
// RAM_WORDS must be a power of two
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Unified RAM depth in 32-bit words, byte range 0x000 to 0x3FF
`define RAM_WORDS 256

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

// Memory-mapped system control registers
// Any nonzero store sets the sticky done flag
`define ADDR_DONE 32'h0000_0400
// Bit 0 of a store drives the LED
`define ADDR_LED 32'h0000_0404

`endif

// File: verilog/soc_pkg.sv
// Shared types for the core and system control
// Opcode values are the RV32I major opcodes
package soc_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_WAIT_INSTR,
        ST_EXECUTE,
        ST_MEM,
        ST_WAIT_DATA,
        ST_WRITEBACK,
        ST_TRAP
    } core_state_e;

    // Address decode result in system control
    typedef enum logic [1:0] {
        RGN_RAM,
        RGN_DONE,
        RGN_LED,
        RGN_NONE
    } region_e;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        alu_op_e     alu_op;
        logic [2:0]  funct3;
        logic        reg_write;
        logic        is_load;
        logic        is_store;
        logic        is_branch;
        logic        is_jump;
        logic        use_imm;
        logic        illegal;
    } decoded_t;

endpackage

// File: verilog/soc_ram.sv
// Word RAM, core bus never back-pressured, host port not arbitrated
// Host port is meant for use while rst is high or after done
`include "soc_consts.svh"

module soc_ram (
    input  logic         clk,
    mem_bus_if.responder bus,
    input  logic         host_we,
    input  logic [7:0]   host_addr,
    input  logic [31:0]  host_wdata,
    output logic [31:0]  host_rdata
);

    localparam int AW = $clog2(`RAM_WORDS);

    logic [31:0]   mem [`RAM_WORDS];
    logic [AW-1:0] bus_idx;

    // Byte address to word index
    assign bus_idx = bus.addr[AW+1:2];
    assign bus.gnt = bus.req;

    always_ff @(posedge clk) begin
        // Core side
        if (bus.req && bus.we) begin
            mem[bus_idx] <= bus.wdata;
        end
        if (bus.req && !bus.we) begin
            bus.rdata <= mem[bus_idx];
        end
        // Host side, read data one cycle after host_addr
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        host_rdata <= mem[host_addr];
    end

    a_no_write_clash: assert property (@(posedge clk)
        !(host_we && bus.req && bus.we && host_addr == bus_idx));

endmodule

// File: verilog/soc_sysctl.sv
// Address decode for the core bus, plus the done flag and LED register
// Register and unmapped reads return zero, done is sticky until rst
`include "soc_consts.svh"

module soc_sysctl (
    input  logic         clk,
    input  logic         rst,
    mem_bus_if.responder core_bus,
    mem_bus_if.requester ram_bus,
    output logic         led,
    output logic         done
);
    import soc_pkg::*;

    localparam logic [31:0] RAM_BYTES = 32'(`RAM_WORDS * 4);

    region_e region;
    logic    rd_ram_q;

    always_comb begin
        if (core_bus.addr < RAM_BYTES) begin
            region = RGN_RAM;
        end else if (core_bus.addr == `ADDR_DONE) begin
            region = RGN_DONE;
        end else if (core_bus.addr == `ADDR_LED) begin
            region = RGN_LED;
        end else begin
            region = RGN_NONE;
        end
    end

    // RAM path
    assign ram_bus.req   = core_bus.req && (region == RGN_RAM);
    assign ram_bus.addr  = core_bus.addr;
    assign ram_bus.we    = core_bus.we;
    assign ram_bus.wdata = core_bus.wdata;

    // Local registers grant at once
    assign core_bus.gnt   = (region == RGN_RAM) ? ram_bus.gnt : core_bus.req;
    assign core_bus.rdata = rd_ram_q ? ram_bus.rdata : 32'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ram_q <= 1'b0;
            done     <= 1'b0;
            led      <= 1'b0;
        end else begin
            // Steers next-cycle read data
            rd_ram_q <= core_bus.gnt && !core_bus.we && (region == RGN_RAM);
            if (core_bus.req && core_bus.we) begin
                if (region == RGN_DONE && core_bus.wdata != 32'd0) begin
                    done <= 1'b1;
                end
                if (region == RGN_LED) begin
                    led <= core_bus.wdata[0];
                end
            end
        end
    end

    a_gnt_needs_req: assert property (@(posedge clk) disable iff (rst)
        core_bus.gnt |-> core_bus.req);

endmodule

// File: verilog/soc_top.sv
// Core, system control and RAM; load programs via the host port in rst
// Host accesses are not arbitrated against the running core
module soc_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        host_we,
    input  logic [7:0]  host_addr,
    input  logic [31:0] host_wdata,
    output logic [31:0] host_rdata,
    output logic        led,
    output logic        done,
    output logic        trap
);

    // Core to system control, system control to RAM
    mem_bus_if core_bus ();
    mem_bus_if ram_bus ();

    rv_core i_core (
        .clk  (clk),
        .rst  (rst),
        .bus  (core_bus.requester),
        .trap (trap)
    );

    soc_sysctl i_sysctl (
        .clk      (clk),
        .rst      (rst),
        .core_bus (core_bus.responder),
        .ram_bus  (ram_bus.requester),
        .led      (led),
        .done     (done)
    );

    soc_ram i_ram (
        .clk        (clk),
        .bus        (ram_bus.responder),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

endmodule
